// File: verilog/uart_rx_defs.svh
`ifndef UART_RX_DEFS_SVH
`define UART_RX_DEFS_SVH

// Default oversampling ratio, rx_clk cycles per serial bit.
`define UART_CLKS_PER_BIT 16

// 8N1 framing.
`define UART_DATA_BITS 8

// Default number of bytes buffered ahead of the stream output.
`define UART_FIFO_DEPTH 4

`endif

// File: verilog/uart_rx_pkg.sv
`include "uart_rx_defs.svh"

package uart_rx_pkg;

    // One received data byte.
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // Position of the data bit being shifted in.
    typedef logic [$clog2(`UART_DATA_BITS)-1:0] bit_index_t;

    // Decoder FSM states.
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // Waiting for a start edge.
        START = 2'd1, // Confirming start bit at mid-bit.
        DATA  = 2'd2, // Shifting in data, LSB first.
        STOP  = 2'd3  // Checking the stop bit.
    } frame_state_t;

endpackage

// File: verilog/rx_bit_sampler.sv
`timescale 1ns/1ps

`include "uart_rx_defs.svh"

module rx_bit_sampler #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic rx_clk,
    input  logic arst_n,
    input  logic rxd,
    input  logic frame_active,
    output logic start_seen,
    output logic sample_strobe,
    output logic sample_bit
);

    localparam int HALF  = CLKS_PER_BIT / 2;
    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic             sync_q1;
    logic             sync_q2;
    logic             prev_q;
    logic [CNT_W-1:0] tick_cnt;
    logic             fall_edge;
    logic             running;

    assign fall_edge = prev_q & ~sync_q2;    // High to low on the synced line.
    // start_seen covers the cycle before the decoder raises frame_active.
    assign running   = frame_active | start_seen;

    always_ff @(posedge rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= 1'b1;                 // Idle line is high.
            sync_q2 <= 1'b1;
            prev_q  <= 1'b1;
        end else begin
            sync_q1 <= rxd;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    always_ff @(posedge rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            start_seen    <= 1'b0;
            sample_strobe <= 1'b0;
            sample_bit    <= 1'b1;
            tick_cnt      <= '0;
        end else begin
            start_seen    <= 1'b0;
            sample_strobe <= 1'b0;
            if (!running) begin
                if (fall_edge) begin
                    start_seen <= 1'b1;
                    // First strobe lands HALF cycles after the edge.
                    tick_cnt   <= CNT_W'(HALF - 2);
                end
            end else if (tick_cnt == '0) begin
                sample_strobe <= 1'b1;
                sample_bit    <= sync_q2;
                tick_cnt      <= CNT_W'(CLKS_PER_BIT - 1);  // One bit time to next.
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

endmodule

// File: verilog/rx_frame_decoder.sv
`timescale 1ns/1ps

`include "uart_rx_defs.svh"

module rx_frame_decoder (
    input  logic                   rx_clk,
    input  logic                   arst_n,
    input  logic                   start_seen,
    input  logic                   sample_strobe,
    input  logic                   sample_bit,
    output logic                   frame_active,
    output logic                   push,
    output uart_rx_pkg::uart_byte_t push_data,
    output logic                   framing_error
);

    localparam uart_rx_pkg::bit_index_t LAST_BIT =
        uart_rx_pkg::bit_index_t'(`UART_DATA_BITS - 1);

    uart_rx_pkg::frame_state_t state_q;
    uart_rx_pkg::bit_index_t   bit_idx;
    uart_rx_pkg::uart_byte_t   shift_q;

    assign frame_active = (state_q != uart_rx_pkg::IDLE);
    assign push_data    = shift_q;        // Stable until the next frame shifts.

    always_ff @(posedge rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= uart_rx_pkg::IDLE;
            bit_idx       <= '0;
            push          <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            push          <= 1'b0;
            framing_error <= 1'b0;
            case (state_q)
                uart_rx_pkg::IDLE: begin
                    if (start_seen) begin
                        state_q <= uart_rx_pkg::START;
                    end
                end
                uart_rx_pkg::START: begin
                    if (sample_strobe) begin
                        bit_idx <= '0;
                        // Line back high by mid-bit is a glitch.
                        state_q <= sample_bit ? uart_rx_pkg::IDLE : uart_rx_pkg::DATA;
                    end
                end
                uart_rx_pkg::DATA: begin
                    if (sample_strobe) begin
                        if (bit_idx == LAST_BIT) begin
                            state_q <= uart_rx_pkg::STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_rx_pkg::STOP: begin
                    if (sample_strobe) begin
                        push          <= sample_bit;    // Good stop bit.
                        framing_error <= ~sample_bit;   // Byte is dropped.
                        state_q       <= uart_rx_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= uart_rx_pkg::IDLE;
                end
            endcase
        end
    end

    // Data bits arrive LSB first, so shift in from the top.
    always_ff @(posedge rx_clk) begin
        if (sample_strobe && state_q == uart_rx_pkg::DATA) begin
            shift_q <= {sample_bit, shift_q[`UART_DATA_BITS-1:1]};
        end
    end

endmodule

// File: verilog/rx_byte_fifo.sv
`timescale 1ns/1ps

`include "uart_rx_defs.svh"

module rx_byte_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                    rx_clk,
    input  logic                    arst_n,
    input  logic                    push,
    input  uart_rx_pkg::uart_byte_t push_data,
    output uart_rx_pkg::uart_byte_t m_data,
    output logic                    m_valid,
    input  logic                    m_ready,
    output logic                    overrun
);

    localparam int PTR_W = $clog2(DEPTH);

    uart_rx_pkg::uart_byte_t mem [DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          count_q;
    logic                    full;
    logic                    pop;
    logic                    accept;

    assign full    = (count_q == (PTR_W + 1)'(DEPTH));
    assign m_valid = (count_q != '0);
    assign m_data  = mem[rd_ptr];
    assign pop     = m_valid & m_ready;
    assign accept  = push & (~full | pop);   // A pop frees the slot this cycle.

    always_ff @(posedge rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
            overrun <= 1'b0;
        end else begin
            overrun <= push & ~accept;
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;     // Wraps, depth is a power of two.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({accept, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge rx_clk) begin
        if (accept) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ps

`include "uart_rx_defs.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT,
    parameter int DEPTH        = `UART_FIFO_DEPTH
) (
    input  logic                    rx_clk,
    input  logic                    arst_n,
    input  logic                    rxd,
    output uart_rx_pkg::uart_byte_t m_data,
    output logic                    m_valid,
    input  logic                    m_ready,
    output logic                    framing_error,
    output logic                    overrun
);

    logic                    start_seen;
    logic                    sample_strobe;
    logic                    sample_bit;
    logic                    frame_active;
    logic                    push;
    uart_rx_pkg::uart_byte_t push_data;

    // Line sync and mid-bit timing.
    rx_bit_sampler #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_sampler (
        .rx_clk       (rx_clk),
        .arst_n       (arst_n),
        .rxd          (rxd),
        .frame_active (frame_active),
        .start_seen   (start_seen),
        .sample_strobe(sample_strobe),
        .sample_bit   (sample_bit)
    );

    rx_frame_decoder u_decoder (
        .rx_clk       (rx_clk),
        .arst_n       (arst_n),
        .start_seen   (start_seen),
        .sample_strobe(sample_strobe),
        .sample_bit   (sample_bit),
        .frame_active (frame_active),
        .push         (push),
        .push_data    (push_data),
        .framing_error(framing_error)
    );

    // Buffers bytes toward the stream consumer.
    rx_byte_fifo #(
        .DEPTH(DEPTH)
    ) u_fifo (
        .rx_clk   (rx_clk),
        .arst_n   (arst_n),
        .push     (push),
        .push_data(push_data),
        .m_data   (m_data),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .overrun  (overrun)
    );

endmodule

// File: tests/uart_rx_tb.sv
`timescale 1ns/1ps

module uart_rx_tb;

    localparam int CPB        = 8;
    localparam int DEPTH      = 4;
    localparam int N_FRAMES   = 34;
    localparam int TIMEOUT_NS = N_FRAMES * 10 * CPB * 4 * 2 + 4000;
    localparam int POLL_LIMIT = 40 * CPB;

    logic                    rx_clk;
    logic                    arst_n;
    logic                    rxd;
    logic                    m_ready;
    uart_rx_pkg::uart_byte_t m_data;
    logic                    m_valid;
    logic                    framing_error;
    logic                    overrun;

    uart_rx_pkg::uart_byte_t exp_q[$];
    uart_rx_pkg::uart_byte_t stall_data;
    logic [31:0]             lfsr_q;
    logic                    stalled;
    int                      errors;
    int                      transfers;
    int                      tests_done;
    int                      fe_count;
    int                      ovr_count;
    int                      exp_fe;
    int                      exp_ovr;

    uart_rx #(
        .CLKS_PER_BIT(CPB),
        .DEPTH       (DEPTH)
    ) DUT (
        .rx_clk       (rx_clk),
        .arst_n       (arst_n),
        .rxd          (rxd),
        .m_data       (m_data),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .framing_error(framing_error),
        .overrun      (overrun)
    );

    initial rx_clk = 1'b0;
    always #2 rx_clk = ~rx_clk;

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic uart_rx_pkg::uart_byte_t random_byte();
        uart_rx_pkg::uart_byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b[i]   = lfsr_q[0];               // One step per bit.
        end
        return b;
    endfunction

    task automatic next_bit();
        repeat (CPB) @(posedge rx_clk);
        #1;
    endtask

    // Glitch mode sends only a short low pulse instead of a frame.
    task automatic send_frame(input uart_rx_pkg::uart_byte_t data, input logic stop_bit,
                              input bit glitch = 1'b0);
        uart_rx_pkg::bit_index_t idx;
        @(posedge rx_clk);
        #1;
        rxd = 1'b0;
        if (glitch) begin
            repeat (CPB / 4) @(posedge rx_clk);
            #1;
            rxd = 1'b1;
        end else begin
            next_bit();
            idx = '0;
            do begin
                rxd = data[idx];              // LSB first.
                next_bit();
                idx++;
            end while (idx != '0);
            rxd = stop_bit;
            next_bit();
            rxd = 1'b1;
        end
    endtask

    task automatic check_idle_flags(input string when);
        assert (m_valid == 1'b0) else begin
            $display("Fail %0t m_valid expected 0 got %b (%s)", $time, m_valid, when);
            errors++;
        end
        assert (framing_error == 1'b0) else begin
            $display("Fail %0t framing_error expected 0 got %b (%s)", $time, framing_error, when);
            errors++;
        end
        assert (overrun == 1'b0) else begin
            $display("Fail %0t overrun expected 0 got %b (%s)", $time, overrun, when);
            errors++;
        end
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || m_valid) && n < POLL_LIMIT) begin
            @(posedge rx_clk);
            #1;
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d expected bytes never came out", what, exp_q.size());
            errors++;
        end
    endtask

    // Waits for the expected error pulses, then checks the exact counts.
    task automatic settle_flags();
        int n;
        n = 0;
        while ((fe_count < exp_fe || ovr_count < exp_ovr) && n < POLL_LIMIT) begin
            @(posedge rx_clk);
            #1;
            n++;
        end
        assert (fe_count == exp_fe) else begin
            $display("Fail %0t framing_error pulses expected %0d got %0d", $time, exp_fe,
                     fe_count);
            errors++;
        end
        assert (ovr_count == exp_ovr) else begin
            $display("Fail %0t overrun pulses expected %0d got %0d", $time, exp_ovr, ovr_count);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        tests_done++;
        $display("Test %-16s finished at %0t, errors so far %0d", name, $time, errors);
    endtask

    // Inputs change 1 ns after the rising edge, so the falling edge sees settled values.
    always @(negedge rx_clk) begin
        if (!arst_n) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                assert (m_valid) else begin
                    $display("m_valid dropped at %0t while m_ready was low", $time);
                    errors++;
                end
                assert (m_data == stall_data) else begin
                    $display("Fail %0t m_data expected %h got %h", $time, stall_data, m_data);
                    errors++;
                end
            end
            if (m_valid && m_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("Byte %h transferred at %0t with nothing expected", m_data, $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    assert (m_data == exp_q[0]) else begin
                        $display("Fail %0t m_data expected %h got %h", $time, exp_q[0], m_data);
                        errors++;
                    end
                    void'(exp_q.pop_front());
                end
                transfers++;
            end
            if (framing_error) fe_count++;
            if (overrun) ovr_count++;
            stalled    = m_valid && !m_ready;
            stall_data = m_data;
        end
    end

    assert property (@(posedge rx_clk) disable iff (!arst_n) overrun |=> !overrun)
        else begin
            $display("overrun stayed high for more than one cycle at %0t", $time);
            errors++;
        end

    assert property (@(posedge rx_clk) disable iff (!arst_n) framing_error |=> !framing_error)
        else begin
            $display("framing_error stayed high for more than one cycle at %0t", $time);
            errors++;
        end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        uart_rx_pkg::uart_byte_t b;
        int                      tr0;
        lfsr_q     = 32'ha6bc9479;
        errors     = 0;
        transfers  = 0;
        tests_done = 0;
        fe_count   = 0;
        ovr_count  = 0;
        exp_fe     = 0;
        exp_ovr    = 0;
        stalled    = 1'b0;
        rxd        = 1'b1;                    // Idle line.
        m_ready    = 1'b0;
        arst_n     = 1'b0;

        repeat (10) begin
            @(posedge rx_clk);
            #1;
            check_idle_flags("during reset");
        end
        arst_n = 1'b1;
        repeat (3) begin
            @(posedge rx_clk);
            #1;
            check_idle_flags("after reset");
        end
        test_done("reset");

        m_ready = 1'b1;
        repeat (20) begin
            b = random_byte();
            exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        wait_drained("data integrity");
        test_done("data integrity");

        m_ready = 1'b0;
        repeat (DEPTH) begin
            b = random_byte();
            exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        next_bit();                           // Last push reaches the FIFO.
        assert (m_valid) else begin
            $display("Fail %0t m_valid expected 1 got %b", $time, m_valid);
            errors++;
        end
        assert (m_data == exp_q[0]) else begin
            $display("Fail %0t m_data expected %h got %h", $time, exp_q[0], m_data);
            errors++;
        end
        m_ready = 1'b1;
        wait_drained("back-pressure");
        settle_flags();
        test_done("back-pressure");

        m_ready = 1'b0;
        for (int i = 0; i < DEPTH + 2; i++) begin
            b = random_byte();
            if (i < DEPTH) exp_q.push_back(b);  // Last two are dropped.
            send_frame(b, 1'b1);
        end
        exp_ovr += 2;
        settle_flags();
        m_ready = 1'b1;
        wait_drained("overrun");
        settle_flags();
        test_done("overrun");

        tr0 = transfers;
        send_frame(random_byte(), 1'b0);
        exp_fe++;
        settle_flags();
        next_bit();
        assert (transfers == tr0) else begin
            $display("A frame with a bad stop bit was transferred");
            errors++;
        end
        b = random_byte();
        exp_q.push_back(b);
        send_frame(b, 1'b1);
        wait_drained("framing error");
        settle_flags();
        test_done("framing error");

        tr0 = transfers;
        send_frame(8'h00, 1'b1, 1'b1);
        // A frame started by the pulse would have finished by now.
        repeat (10) next_bit();
        assert (transfers == tr0) else begin
            $display("A short low pulse produced a transfer");
            errors++;
        end
        settle_flags();
        b = random_byte();
        exp_q.push_back(b);
        send_frame(b, 1'b1);
        wait_drained("false start");
        settle_flags();
        test_done("false start");

        $display("Tests %0d, transfers %0d, framing errors %0d, overruns %0d, errors %0d",
                 tests_done, transfers, fe_count, ovr_count, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/uart_rx_pkg.sv
verilog/rx_bit_sampler.sv
verilog/rx_frame_decoder.sv
verilog/rx_byte_fifo.sv
verilog/uart_rx.sv
tests/uart_rx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the UART receiver testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module uart_rx_tb -f all.f -o uart_rx_sim \
    && ./obj_dir/uart_rx_sim | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null \
    && echo "uart_rx simulation passed" \
    || { echo "uart_rx simulation failed"; exit 1; }
